// ==== tlp_pkg.sv ====
package tlp_pkg;

	////////////////////
	// Header field codes

	// Format field, header word 0 bits 7:5
	typedef enum logic [2:0] {
		fmt_3dw_nodata = 3'd0,
		fmt_4dw_nodata = 3'd1,
		fmt_3dw_data   = 3'd2,
		fmt_4dw_data   = 3'd3,
		// TLP prefix, never accepted here
		fmt_prefix     = 3'd4
	} tlp_format_t;

	// Type field, header word 0 bits 4:0
	typedef enum logic [4:0] {
		type_mem        = 5'd0,
		type_mem_locked = 5'd1,
		type_io         = 5'd2,
		type_cfg0       = 5'd4,
		type_cfg1       = 5'd5,
		type_cpl        = 5'd10,
		type_cpl_locked = 5'd11
	} tlp_type_t;

	////////////////////
	// Header bit positions

	// Word 0
	localparam int fmt_msb    = 7;
	localparam int fmt_lsb    = 5;
	localparam int type_msb   = 4;
	localparam int type_lsb   = 0;
	localparam int poison_bit = 22;
	// Length high part, then low byte
	localparam int len_hi_msb = 17;
	localparam int len_hi_lsb = 16;
	localparam int len_lo_msb = 31;
	localparam int len_lo_lsb = 24;

	// Word 1
	localparam int req_id_msb = 15;
	localparam int req_id_lsb = 0;
	localparam int tag_msb    = 23;
	localparam int tag_lsb    = 16;

	// Word 2, address still in wire byte order
	localparam int bus_msb    = 7;
	localparam int bus_lsb    = 0;
	localparam int dev_msb    = 15;
	localparam int dev_lsb    = 11;

	////////////////////
	// Queued request

	// One accepted type 0 config write
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [9:0]  len;
		logic [15:0] requester;
		logic [7:0]  tag;
		logic [7:0]  bus;
		logic [4:0]  device;
	} cfg_req_t;

endpackage

// ==== tlp_rx_parser.sv ====
`timescale 1ns/1ps

module tlp_rx_parser (
	input  logic              axi_tlp_rx,
	input  logic              reset,
	input  logic              dl_link_up,
	// Incoming TLP words from the data link layer
	input  logic              rx_tvalid,
	input  logic [31:0]       rx_tdata,
	input  logic              rx_tlast,
	// CRC error flag that only counts together with rx_tlast
	input  logic              rx_tuser,
	output logic              rx_tready,
	// Request buffer write side
	output logic              req_wr,
	output tlp_pkg::cfg_req_t req_wdata,
	input  logic              req_full
);

	typedef enum logic [2:0] {
		st_idle,
		st_hdr1,
		st_hdr2,
		st_cfg_data,
		st_drop
	} state_t;

	state_t state;

	// Word transfer on this edge
	logic accept;

	// Fields captured from the header words
	tlp_pkg::tlp_format_t fmt;
	tlp_pkg::tlp_type_t   typ;
	logic [9:0]           len;
	logic [15:0]          requester;
	logic [7:0]           tag;
	logic [31:0]          addr;
	logic [7:0]           bus;
	logic [4:0]           device;

	assign accept = rx_tvalid && rx_tready;

	////////////////////
	// Control

	always_ff @(posedge axi_tlp_rx) begin
		if (reset) begin
			state     <= st_idle;
			rx_tready <= 1'b1;
			req_wr    <= 1'b0;
		end else begin
			// Stall the input one cycle after the buffer fills
			rx_tready <= !req_full;
			req_wr    <= 1'b0;

			if (accept) begin
				case (state)
					// Header word 0
					st_idle: begin
						// Poisoned TLPs are discarded whole
						if (rx_tdata[tlp_pkg::poison_bit])
							state <= st_drop;
						else
							state <= st_hdr1;
					end

					// Requester and tag word with byte enables ignored
					st_hdr1: begin
						state <= st_hdr2;
					end

					// Address word completes the header
					st_hdr2: begin
						if (fmt == tlp_pkg::fmt_3dw_data && typ == tlp_pkg::type_cfg0 &&
								len == 10'd1)
							state <= st_cfg_data;
						else
							state <= st_drop;
					end

					// Single data word that must carry last
					st_cfg_data: begin
						// Bad CRC or a lost link means no write
						if (rx_tlast && !rx_tuser && dl_link_up)
							req_wr <= 1'b1;
						// Extra data words are malformed
						state <= st_drop;
					end

					// Wait for the end of the TLP
					st_drop: begin
						state <= st_drop;
					end

					default: begin
						state <= st_drop;
					end
				endcase

				// Nothing gets through without a link
				if (!dl_link_up)
					state <= st_drop;

				// Every TLP ends back in idle
				if (rx_tlast)
					state <= st_idle;
			end
		end
	end

	////////////////////
	// Header capture

	always_ff @(posedge axi_tlp_rx) begin
		if (accept) begin
			case (state)
				st_idle: begin
					fmt <= tlp_pkg::tlp_format_t'(rx_tdata[tlp_pkg::fmt_msb:tlp_pkg::fmt_lsb]);
					typ <= tlp_pkg::tlp_type_t'(rx_tdata[tlp_pkg::type_msb:tlp_pkg::type_lsb]);
					len <= {rx_tdata[tlp_pkg::len_hi_msb:tlp_pkg::len_hi_lsb],
						rx_tdata[tlp_pkg::len_lo_msb:tlp_pkg::len_lo_lsb]};
				end
				st_hdr1: begin
					requester <= rx_tdata[tlp_pkg::req_id_msb:tlp_pkg::req_id_lsb];
					tag       <= rx_tdata[tlp_pkg::tag_msb:tlp_pkg::tag_lsb];
				end
				st_hdr2: begin
					// Address arrives byte-reversed
					addr   <= {rx_tdata[7:0], rx_tdata[15:8], rx_tdata[23:16], rx_tdata[31:24]};
					// Bus and device come from every config write
					bus    <= rx_tdata[tlp_pkg::bus_msb:tlp_pkg::bus_lsb];
					device <= rx_tdata[tlp_pkg::dev_msb:tlp_pkg::dev_lsb];
				end
				st_cfg_data: begin
					req_wdata.addr      <= addr;
					req_wdata.wdata     <= rx_tdata;
					req_wdata.len       <= len;
					req_wdata.requester <= requester;
					req_wdata.tag       <= tag;
					req_wdata.bus       <= bus;
					req_wdata.device    <= device;
				end
				default: begin
				end
			endcase
		end
	end

	// The registered tready must keep writes away from a full buffer
	assert property (@(posedge axi_tlp_rx) disable iff (reset) req_wr |-> !req_full)
		else $error("parser wrote a request into a full buffer");

endmodule

// ==== tlp_req_fifo.sv ====
`timescale 1ns/1ps

module tlp_req_fifo #(
	parameter type payload_t = logic [31:0],
	// Entry count, power of two
	parameter int  depth     = 4
) (
	input  logic     axi_tlp_rx,
	input  logic     reset,
	// Write side
	input  logic     wr,
	input  payload_t wdata,
	output logic     full,
	// Read side, head shown while valid
	output logic     valid,
	output payload_t rdata,
	input  logic     pop
);

	localparam int ptr_w = $clog2(depth);
	localparam int cnt_w = $clog2(depth + 1);
	localparam logic [cnt_w-1:0] max_cnt = cnt_w'(depth);

	payload_t mem [depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;

	// Qualified strobes
	logic do_wr;
	logic do_pop;

	assign full   = (count == max_cnt);
	assign valid  = (count != '0);
	assign rdata  = mem[rd_ptr];
	assign do_wr  = wr && !full;
	assign do_pop = pop && valid;

	////////////////////
	// Pointers and count

	always_ff @(posedge axi_tlp_rx) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap on their own
			if (do_wr)
				wr_ptr <= wr_ptr + ptr_w'(1);
			if (do_pop)
				rd_ptr <= rd_ptr + ptr_w'(1);
			case ({do_wr, do_pop})
				2'b10:   count <= count + cnt_w'(1);
				2'b01:   count <= count - cnt_w'(1);
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge axi_tlp_rx) begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
	end

	// Producer and consumer both must respect the flags
	assert property (@(posedge axi_tlp_rx) disable iff (reset) pop |-> valid)
		else $error("pop from an empty buffer");
	assert property (@(posedge axi_tlp_rx) disable iff (reset) wr |-> !full)
		else $error("write to a full buffer");

endmodule

// ==== tlp_cfg_completer.sv ====
`timescale 1ns/1ps

module tlp_cfg_completer (
	input  logic              axi_tlp_rx,
	input  logic              reset,
	// Request buffer read side
	input  logic              req_valid,
	input  tlp_pkg::cfg_req_t req_rdata,
	output logic              req_pop,
	// Config bus, writes only
	output logic              apb_psel,
	output logic              apb_penable,
	output logic [31:0]       apb_paddr,
	output logic [31:0]       apb_pwdata,
	input  logic              apb_pready,
	// Outgoing completion, no back-pressure
	output logic              tx_tvalid,
	output logic [31:0]       tx_tdata,
	output logic              tx_tlast
);

	// Request being served
	tlp_pkg::cfg_req_t req;

	// Request in flight
	logic busy;
	// APB write finished
	logic apb_done;
	// Next completion word, 3 once all are sent
	logic [1:0] tx_word;

	// Fixed completion header
	logic [31:0] cpl_word0;
	logic [31:0] cpl_word1;
	logic [31:0] cpl_word2;

	assign req_pop = !busy && req_valid;

	assign apb_paddr  = req.addr;
	assign apb_pwdata = req.wdata;

	////////////////////
	// Completion words

	// 3DW no data, completion type
	assign cpl_word0 = {24'h0, tlp_pkg::fmt_3dw_nodata, tlp_pkg::type_cpl};

	// Completer ID, status always success, byte count from length
	assign cpl_word1 = {req.len[5:0], 2'b00, 4'h0, req.len[9:6], req.device, 3'b000, req.bus};

	// Requester and tag replayed, lower address zero for config
	assign cpl_word2 = {8'h00, req.tag, req.requester};

	////////////////////
	// Control

	always_ff @(posedge axi_tlp_rx) begin
		if (reset) begin
			busy        <= 1'b0;
			apb_done    <= 1'b0;
			tx_word     <= 2'd0;
			apb_psel    <= 1'b0;
			apb_penable <= 1'b0;
			tx_tvalid   <= 1'b0;
			tx_tlast    <= 1'b0;
		end else begin
			// Single cycle strobes
			tx_tvalid <= 1'b0;
			tx_tlast  <= 1'b0;

			if (req_pop) begin
				busy      <= 1'b1;
				apb_done  <= 1'b0;
				// APB setup phase
				apb_psel  <= 1'b1;
				// Completion word 0 goes out right away
				tx_tvalid <= 1'b1;
				tx_word   <= 2'd1;
			end else if (busy) begin
				// Setup to access
				if (apb_psel && !apb_penable) begin
					apb_penable <= 1'b1;
				end else if (apb_penable && apb_pready) begin
					apb_psel    <= 1'b0;
					apb_penable <= 1'b0;
					apb_done    <= 1'b1;
				end

				// Remaining completion words run alongside the write
				case (tx_word)
					2'd1: begin
						tx_tvalid <= 1'b1;
						tx_word   <= 2'd2;
					end
					2'd2: begin
						tx_tvalid <= 1'b1;
						tx_tlast  <= 1'b1;
						tx_word   <= 2'd3;
					end
					default: begin
					end
				endcase

				// Both sides finished
				if (apb_done && tx_word == 2'd3)
					busy <= 1'b0;
			end
		end
	end

	////////////////////
	// Payload

	always_ff @(posedge axi_tlp_rx) begin
		if (req_pop) begin
			req      <= req_rdata;
			tx_tdata <= cpl_word0;
		end else if (tx_word == 2'd1) begin
			tx_tdata <= cpl_word1;
		end else if (tx_word == 2'd2) begin
			tx_tdata <= cpl_word2;
		end
	end

	// Address must hold across setup and access until pready
	assert property (@(posedge axi_tlp_rx) disable iff (reset)
		apb_psel && !(apb_penable && apb_pready) |=> apb_psel && $stable(apb_paddr))
		else $error("APB address changed before the transfer completed");

endmodule

// ==== tlp_transaction_layer.sv ====
`timescale 1ns/1ps

module tlp_transaction_layer #(
	// Buffered requests, power of two
	parameter int fifo_depth = 4
) (
	input  logic        axi_tlp_rx,
	input  logic        reset,
	input  logic        dl_link_up,
	// TLPs from the data link layer
	input  logic        rx_tvalid,
	input  logic [31:0] rx_tdata,
	input  logic        rx_tlast,
	input  logic        rx_tuser,
	output logic        rx_tready,
	// Config register bus
	output logic        apb_psel,
	output logic        apb_penable,
	output logic [31:0] apb_paddr,
	output logic [31:0] apb_pwdata,
	input  logic        apb_pready,
	// Completions to the data link layer
	output logic        tx_tvalid,
	output logic [31:0] tx_tdata,
	output logic        tx_tlast
);

	// Parser to buffer
	logic              req_wr;
	tlp_pkg::cfg_req_t req_wdata;
	logic              req_full;

	// Buffer to completer
	logic              req_valid;
	tlp_pkg::cfg_req_t req_rdata;
	logic              req_pop;

	////////////////////
	// Receive path

	tlp_rx_parser tlp_rx_parser_inst (
		.axi_tlp_rx (axi_tlp_rx),
		.reset      (reset),
		.dl_link_up (dl_link_up),
		.rx_tvalid  (rx_tvalid),
		.rx_tdata   (rx_tdata),
		.rx_tlast   (rx_tlast),
		.rx_tuser   (rx_tuser),
		.rx_tready  (rx_tready),
		.req_wr     (req_wr),
		.req_wdata  (req_wdata),
		.req_full   (req_full)
	);

	// Request queue, whole struct per entry
	tlp_req_fifo #(
		.payload_t (tlp_pkg::cfg_req_t),
		.depth     (fifo_depth)
	) tlp_req_fifo_inst (
		.axi_tlp_rx (axi_tlp_rx),
		.reset      (reset),
		.wr         (req_wr),
		.wdata      (req_wdata),
		.full       (req_full),
		.valid      (req_valid),
		.rdata      (req_rdata),
		.pop        (req_pop)
	);

	////////////////////
	// Completion path

	tlp_cfg_completer tlp_cfg_completer_inst (
		.axi_tlp_rx  (axi_tlp_rx),
		.reset       (reset),
		.req_valid   (req_valid),
		.req_rdata   (req_rdata),
		.req_pop     (req_pop),
		.apb_psel    (apb_psel),
		.apb_penable (apb_penable),
		.apb_paddr   (apb_paddr),
		.apb_pwdata  (apb_pwdata),
		.apb_pready  (apb_pready),
		.tx_tvalid   (tx_tvalid),
		.tx_tdata    (tx_tdata),
		.tx_tlast    (tx_tlast)
	);

endmodule

// ==== tb_tlp_transaction_layer.sv ====
`timescale 1ns/1ps

module tb_tlp_transaction_layer;

	localparam int timeout_cycles = 2000;

	// Header codes for the stimulus
	localparam logic [2:0] fmt_3dw_data = 3'd2;
	localparam logic [2:0] fmt_4dw_data = 3'd3;
	localparam logic [4:0] type_mem     = 5'd0;
	localparam logic [4:0] type_cfg0    = 5'd4;
	localparam logic [4:0] type_cfg1    = 5'd5;

	logic        axi_tlp_rx;
	logic        reset;
	logic        dl_link_up;
	logic        rx_tvalid;
	logic [31:0] rx_tdata;
	logic        rx_tlast;
	logic        rx_tuser;
	logic        rx_tready;
	logic        apb_psel;
	logic        apb_penable;
	logic [31:0] apb_paddr;
	logic [31:0] apb_pwdata;
	logic        apb_pready;
	logic        tx_tvalid;
	logic [31:0] tx_tdata;
	logic        tx_tlast;

	int    errors;
	int    checks;
	int    seed;
	// APB wait states, drawn per transfer
	int    min_delay;
	int    max_delay;
	bit    saw_stall;
	string cur_test;

	// Expected traffic, in order
	logic [31:0] exp_apb_addr [$];
	logic [31:0] exp_apb_data [$];
	logic [31:0] exp_cpl_word [$];
	logic        exp_cpl_last [$];

	tlp_transaction_layer #(
		.fifo_depth (4)
	) tlp_transaction_layer_inst (
		.axi_tlp_rx  (axi_tlp_rx),
		.reset       (reset),
		.dl_link_up  (dl_link_up),
		.rx_tvalid   (rx_tvalid),
		.rx_tdata    (rx_tdata),
		.rx_tlast    (rx_tlast),
		.rx_tuser    (rx_tuser),
		.rx_tready   (rx_tready),
		.apb_psel    (apb_psel),
		.apb_penable (apb_penable),
		.apb_paddr   (apb_paddr),
		.apb_pwdata  (apb_pwdata),
		.apb_pready  (apb_pready),
		.tx_tvalid   (tx_tvalid),
		.tx_tdata    (tx_tdata),
		.tx_tlast    (tx_tlast)
	);

	initial begin
		axi_tlp_rx = 1'b0;
		forever #5 axi_tlp_rx = ~axi_tlp_rx;
	end

	////////////////////
	// Reference model

	function automatic logic [31:0] byte_swap(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic logic [31:0] make_hdr0(input logic [2:0] fmt, input logic [4:0] typ,
			input logic [9:0] len, input logic poison);
		logic [31:0] w;
		w = 32'h0;
		w[7:5] = fmt;
		w[4:0] = typ;
		w[22] = poison;
		// Length split, high bits low in the word
		w[17:16] = len[9:8];
		w[31:24] = len[7:0];
		return w;
	endfunction

	// Address word as it arrives, bus in the low byte
	function automatic logic [31:0] make_addr(input logic [7:0] bus, input logic [4:0] dev,
			input logic [2:0] fn, input logic [7:0] reg_num);
		return {reg_num, 8'h00, dev, fn, bus};
	endfunction

	// Three completion words, word 0 in the low 32 bits
	function automatic logic [95:0] ref_completion(input logic [31:0] addr_w,
			input logic [15:0] requester, input logic [7:0] tag, input logic [9:0] len);
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		// 3DW no data, completion type 10
		w0 = 32'h0000_000a;
		w1 = {len[5:0], 2'b00, 4'h0, len[9:6], addr_w[15:11], 3'b000, addr_w[7:0]};
		w2 = {8'h00, tag, requester};
		return {w2, w1, w0};
	endfunction

	////////////////////
	// Helpers

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// One word, held until the DUT takes it
	task automatic send_word(input logic [31:0] data, input logic last, input logic user);
		int waited;
		waited = 0;
		rx_tvalid = 1'b1;
		rx_tdata  = data;
		rx_tlast  = last;
		rx_tuser  = user;
		while (!rx_tready && waited < timeout_cycles) begin
			@(posedge axi_tlp_rx);
			#1;
			waited++;
		end
		if (!rx_tready) begin
			errors++;
			$display("ERROR: %s rx_tready stayed low, word %h not accepted", cur_test, data);
		end
		@(posedge axi_tlp_rx);
		#1;
		rx_tvalid = 1'b0;
		rx_tlast  = 1'b0;
		rx_tuser  = 1'b0;
	endtask

	task automatic send_header(input logic [31:0] w0, input logic [15:0] requester,
			input logic [7:0] tag, input logic [31:0] addr_w);
		send_word(w0, 1'b0, 1'b0);
		// Byte enables in the top byte
		send_word({8'h0f, tag, requester}, 1'b0, 1'b0);
		send_word(addr_w, 1'b0, 1'b0);
	endtask

	task automatic send_cfg_write(input logic [31:0] addr_w, input logic [31:0] data,
			input logic [15:0] requester, input logic [7:0] tag, input bit expected);
		logic [95:0] cpl;
		int i;
		if (expected) begin
			cpl = ref_completion(addr_w, requester, tag, 10'd1);
			exp_apb_addr.push_back(byte_swap(addr_w));
			exp_apb_data.push_back(data);
			for (i = 0; i < 3; i++) begin
				exp_cpl_word.push_back(cpl[32*i +: 32]);
				exp_cpl_last.push_back(i == 2);
			end
		end
		send_header(make_hdr0(fmt_3dw_data, type_cfg0, 10'd1, 1'b0), requester, tag, addr_w);
		send_word(data, 1'b1, 1'b0);
	endtask

	// Let expected traffic finish, then idle to expose stray output
	task automatic wait_drain();
		int waited;
		waited = 0;
		while ((exp_apb_addr.size() != 0 || exp_cpl_word.size() != 0) &&
				waited < timeout_cycles) begin
			@(posedge axi_tlp_rx);
			#1;
			waited++;
		end
		if (exp_apb_addr.size() != 0 || exp_cpl_word.size() != 0) begin
			errors++;
			$display("ERROR: %s timed out waiting for APB writes and completions", cur_test);
		end
		repeat (20) @(posedge axi_tlp_rx);
		#1;
	endtask

	////////////////////
	// APB slave with random wait states

	initial begin : apb_responder
		int delay_left;
		apb_pready = 1'b0;
		delay_left = 0;
		forever begin
			@(posedge axi_tlp_rx);
			#1;
			if (apb_pready)
				apb_pready = 1'b0;
			else if (apb_psel && !apb_penable)
				delay_left = min_delay + ({$random(seed)} % (max_delay - min_delay + 1));
			else if (apb_psel && apb_penable) begin
				if (delay_left == 0)
					apb_pready = 1'b1;
				else
					delay_left--;
			end
		end
	end

	// Compare at the falling edge, all signals settled
	initial begin : compare_outputs
		logic [31:0] exp_word;
		logic        exp_last;
		forever begin
			@(negedge axi_tlp_rx);
			if (!reset) begin
				if (!rx_tready)
					saw_stall = 1'b1;
				// Transfer ends on the next rising edge
				if (apb_psel && apb_penable && apb_pready) begin
					if (exp_apb_addr.size() == 0) begin
						errors++;
						$display("ERROR: %s unexpected APB write to %h", cur_test, apb_paddr);
					end else begin
						check({cur_test, " apb addr"}, exp_apb_addr.pop_front(), apb_paddr);
						check({cur_test, " apb data"}, exp_apb_data.pop_front(), apb_pwdata);
					end
				end
				if (tx_tvalid) begin
					if (exp_cpl_word.size() == 0) begin
						errors++;
						$display("ERROR: %s unexpected completion word %h", cur_test, tx_tdata);
					end else begin
						exp_word = exp_cpl_word.pop_front();
						exp_last = exp_cpl_last.pop_front();
						check({cur_test, " cpl word"}, exp_word, tx_tdata);
						check({cur_test, " cpl last"}, 32'(exp_last), 32'(tx_tlast));
					end
				end else if (tx_tlast) begin
					errors++;
					$display("ERROR: %s tx_tlast high without tx_tvalid", cur_test);
				end
			end
		end
	end

	////////////////////
	// Stimulus

	initial begin : main_sequence
		logic [31:0] r;
		logic [31:0] a;
		int i;
		errors     = 0;
		checks     = 0;
		seed       = 32'hbfe2060e;
		min_delay  = 0;
		max_delay  = 3;
		saw_stall  = 1'b0;
		cur_test   = "reset";
		reset      = 1'b1;
		dl_link_up = 1'b1;
		rx_tvalid  = 1'b0;
		rx_tdata   = 32'h0;
		rx_tlast   = 1'b0;
		rx_tuser   = 1'b0;
		repeat (5) @(posedge axi_tlp_rx);
		#1;
		check("reset rx_tready", 32'd1, 32'(rx_tready));
		check("reset tx_tvalid", 32'd0, 32'(tx_tvalid));
		check("reset tx_tlast", 32'd0, 32'(tx_tlast));
		check("reset apb_psel", 32'd0, 32'(apb_psel));
		check("reset apb_penable", 32'd0, 32'(apb_penable));
		reset = 1'b0;

		cur_test = "clean_write";
		send_cfg_write(make_addr(8'h03, 5'h02, 3'd0, 8'h10), 32'h1234_5678, 16'h0100, 8'h2a, 1);
		wait_drain();

		// Each of these is discarded whole
		cur_test = "dropped";
		a = make_addr(8'h05, 5'h01, 3'd0, 8'h04);
		send_header(make_hdr0(fmt_3dw_data, type_cfg0, 10'd1, 1'b1), 16'h0100, 8'h01, a);
		send_word(32'hdead_0001, 1'b1, 1'b0);
		send_header(make_hdr0(fmt_3dw_data, type_cfg0, 10'd1, 1'b0), 16'h0100, 8'h02, a);
		send_word(32'hdead_0002, 1'b1, 1'b1);
		send_header(make_hdr0(fmt_3dw_data, type_cfg0, 10'd1, 1'b0), 16'h0100, 8'h03, a);
		send_word(32'hdead_0003, 1'b0, 1'b0);
		send_word(32'hdead_0004, 1'b1, 1'b0);
		send_header(make_hdr0(fmt_4dw_data, type_cfg0, 10'd1, 1'b0), 16'h0100, 8'h04, a);
		send_word(32'h0000_0000, 1'b0, 1'b0);
		send_word(32'hdead_0005, 1'b1, 1'b0);
		send_header(make_hdr0(fmt_3dw_data, type_mem, 10'd1, 1'b0), 16'h0100, 8'h05, a);
		send_word(32'hdead_0006, 1'b1, 1'b0);
		send_header(make_hdr0(fmt_3dw_data, type_cfg1, 10'd1, 1'b0), 16'h0100, 8'h06, a);
		send_word(32'hdead_0007, 1'b1, 1'b0);
		send_cfg_write(make_addr(8'h07, 5'h04, 3'd1, 8'h20), 32'hcafe_f00d, 16'h0200, 8'h07, 1);
		wait_drain();

		cur_test = "link_down";
		dl_link_up = 1'b0;
		send_cfg_write(make_addr(8'h09, 5'h05, 3'd0, 8'h08), 32'h0bad_0001, 16'h0300, 8'h10, 0);
		send_cfg_write(make_addr(8'h0a, 5'h06, 3'd0, 8'h0c), 32'h0bad_0002, 16'h0300, 8'h11, 0);
		repeat (10) @(posedge axi_tlp_rx);
		#1;
		dl_link_up = 1'b1;
		send_cfg_write(make_addr(8'h0b, 5'h07, 3'd2, 8'h14), 32'h600d_0003, 16'h0300, 8'h12, 1);
		wait_drain();

		// Slow APB slave backs the requests up into the FIFO
		cur_test = "burst";
		min_delay = 6;
		max_delay = 14;
		saw_stall = 1'b0;
		for (i = 0; i < 10; i++) begin
			r = $random(seed);
			a = $random(seed);
			send_cfg_write(a, $random(seed), r[15:0], r[23:16], 1);
		end
		wait_drain();
		check("burst rx_tready stall", 32'd1, 32'(saw_stall));
		min_delay = 0;
		max_delay = 3;

		cur_test = "bus_device";
		send_cfg_write(make_addr(8'h12, 5'h03, 3'd0, 8'h00), 32'h0000_0011, 16'h0400, 8'h20, 1);
		send_cfg_write(make_addr(8'ha5, 5'h1f, 3'd7, 8'h3c), 32'h0000_0022, 16'h0401, 8'h21, 1);
		send_cfg_write(make_addr(8'h00, 5'h00, 3'd0, 8'hfc), 32'h0000_0033, 16'h0402, 8'h22, 1);
		send_cfg_write(make_addr(8'hff, 5'h10, 3'd3, 8'h40), 32'h0000_0044, 16'h0403, 8'h23, 1);
		wait_drain();

		if (exp_apb_addr.size() != 0 || exp_cpl_word.size() != 0) begin
			errors++;
			$display("ERROR: %0d APB writes and %0d completion words never appeared",
				exp_apb_addr.size(), exp_cpl_word.size());
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
tlp_pkg.sv
tlp_rx_parser.sv
tlp_req_fifo.sv
tlp_cfg_completer.sv
tlp_transaction_layer.sv
tb_tlp_transaction_layer.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_tlp_transaction_layer -f src.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -q "TESTS PASSED" && echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
